// ==== filelist.f ====
src/controlPkg.sv
src/instrDecode.sv
src/controlSequencer.sv
src/controlOutputs.sv
src/controlUnit.sv
bench/clockGen.sv
bench/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: controlUnit

sources:
  - files:
      - src/controlPkg.sv
      - src/instrDecode.sv
      - src/controlSequencer.sv
      - src/controlOutputs.sv
      - src/controlUnit.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/controlUnitTb.sv

// ==== bench/controlUnitTb.sv ====
`timescale 1ns/10ps

module controlUnitTb import controlPkg::*; ();

    localparam int memWaitCycles = 3;
    localparam int driveDelay    = 10;
    localparam int fixedCount    = 8;
    localparam int fillerCount   = 8;
    localparam int programLength = fixedCount + fillerCount + 1;  // Last entry is halt
    localparam int haltHold      = 12;
    localparam int timeoutCycles = (programLength + 4) * 10 + 40;

    localparam int kindAlu  = 0;
    localparam int kindSlt  = 1;
    localparam int kindAddi = 2;
    localparam int kindSll  = 3;
    localparam int kindNone = 4;
    localparam int kindHalt = 5;

    // Order is add, sub, and, slt, addi, sll
    localparam logic [5:0] knownOp [6] = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h08, 6'h00};
    localparam logic [5:0] knownFn [6] = '{6'h20, 6'h22, 6'h24, 6'h2a, 6'h00, 6'h00};
    localparam int knownKind [6] = '{kindAlu, kindAlu, kindAlu, kindSlt, kindAddi, kindSll};
    localparam int knownLength [6] = '{2, 2, 2, 1, 2, 3};
    localparam aluOpT knownAlu [6] = '{aluAdd, aluSub, aluAnd, aluSlt, aluAdd, aluPass};

    logic clock;
    logic reset;
    logic resetRequest;
    opcodeT opcode;
    functT funct;
    logic pcWrite;
    logic memReadWrite;
    logic irWrite;
    logic regWrite;
    logic aWrite;
    logic bWrite;
    logic aluOutWrite;
    aluOpT aluOp;
    logic srcASel;
    logic [srcBSelWidth-1:0] srcBSel;
    logic [regDestSelWidth-1:0] regDestSel;
    logic [memToRegSelWidth-1:0] memToRegSel;
    logic shiftAmtSel;
    logic shiftSrcSel;
    shiftOpT shiftCtrl;
    logic resetOut;

    logic [6:0] strobes;
    logic waitCycle;
    logic allQuiet;
    int cycleCount = 0;
    int waitRun = 0;
    int gap = 0;
    int regSeen = 0;
    logic fetchSeen = 1'b0;
    int expKind;
    int expGap;
    int expWrites;
    aluOpT expAlu;
    logic [3:0] expMemToReg;
    logic [5:0] progOp [programLength];
    logic [5:0] progFn [programLength];
    logic [31:0] rngState;

    clockGen clocks (
        .resetRequest (resetRequest),
        .clock        (clock),
        .reset        (reset)
    );

    controlUnit #(
        .memWaitCycles (memWaitCycles)
    ) uut (
        .clock (clock), .reset (reset), .opcode (opcode), .funct (funct),
        .pcWrite (pcWrite), .memReadWrite (memReadWrite), .irWrite (irWrite),
        .regWrite (regWrite), .aWrite (aWrite), .bWrite (bWrite),
        .aluOutWrite (aluOutWrite), .aluOp (aluOp), .srcASel (srcASel),
        .srcBSel (srcBSel), .regDestSel (regDestSel), .memToRegSel (memToRegSel),
        .shiftAmtSel (shiftAmtSel), .shiftSrcSel (shiftSrcSel),
        .shiftCtrl (shiftCtrl), .resetOut (resetOut)
    );

    assign strobes = {pcWrite, memReadWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite};
    assign waitCycle = !reset && strobes == '0 && !resetOut && aluOp == aluAdd && srcBSel == 1;
    assign allQuiet = strobes == '0 && !resetOut && aluOp == aluPass && !srcASel &&
                      srcBSel == '0 && regDestSel == '0 && memToRegSel == '0 &&
                      !shiftAmtSel && !shiftSrcSel && shiftCtrl == shiftNone;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (reset) begin
            waitRun   <= 0;
            gap       <= 0;
            regSeen   <= 0;
            fetchSeen <= 1'b0;
        end else begin
            waitRun <= waitCycle ? waitRun + 1 : 0;           // Consecutive memory wait cycles
            gap     <= irWrite ? 1 : gap + 1;
            regSeen <= irWrite ? 0 : regSeen + int'(regWrite);
            if (irWrite) begin
                fetchSeen <= 1'b1;
            end
        end
    end

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic reportError(input string message);
        $display("ERROR at %0t ns: %s", $time, message);
        abortRun();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    resetQuiet: assert property (@(posedge clock)
        cycleCount > 0 && reset && $past(reset) |-> strobes == '0 && !resetOut)
        else reportError("strobe or resetOut active during reset");
    firstCycle: assert property (@(posedge clock)
        $fell(reset) |-> strobes == '0 && !resetOut && aluOp == aluAdd && srcBSel == 1)
        else reportError("first cycle after reset is not a fetch wait");
    pcWithIr: assert property (@(posedge clock) cycleCount > 0 |-> pcWrite == irWrite)
        else reportError("pcWrite and irWrite differ");
    regReadFollows: assert property (@(posedge clock) $past(irWrite) |-> aWrite && bWrite)
        else reportError("no aWrite and bWrite after irWrite");
    decodeQuiet: assert property (@(posedge clock) $past(irWrite, 2) |-> allQuiet)
        else reportError("decode cycle drives an output");
    fetchWait: assert property (@(posedge clock) irWrite |-> waitRun == memWaitCycles)
        else reportError("wrong number of memory wait cycles before irWrite");
    gapCheck: assert property (@(posedge clock) irWrite && fetchSeen |-> gap == expGap)
        else reportError("wrong instruction length between irWrite pulses");
    writeCount: assert property (@(posedge clock) irWrite && fetchSeen |-> regSeen == expWrites)
        else reportError("wrong number of regWrite pulses for the instruction");
    aluWrite: assert property (@(posedge clock)
        regWrite && (expKind == kindAlu || expKind == kindSlt) |->
        regDestSel == 1 && aluOp == expAlu && memToRegSel == expMemToReg && srcASel &&
        aluOutWrite == (expKind == kindAlu))
        else reportError("R-type write back has wrong selects or ALU operation");
    addiWrite: assert property (@(posedge clock) regWrite && expKind == kindAddi |->
        regDestSel == 0 && $past(aluOp) == aluAdd && $past(srcBSel) == 2 &&
        $past(aluOutWrite) && srcASel)
        else reportError("addi write back has wrong selects");
    sllWrite: assert property (@(posedge clock) regWrite && expKind == kindSll |->
        memToRegSel == 8 && regDestSel == 1 && shiftCtrl == shiftLeft &&
        $past(shiftCtrl) == shiftLeft && $past(shiftCtrl, 2) == shiftLoad &&
        $past(shiftAmtSel, 2) && $past(shiftSrcSel, 2))
        else reportError("sll write back does not follow load and two shifts");
    noWrite: assert property (@(posedge clock)
        regWrite |-> expKind != kindNone && expKind != kindHalt)
        else reportError("regWrite for an unknown or halt instruction");
    haltRises: assert property (@(posedge clock)
        $past(irWrite, 3) && $past(expKind, 2) == kindHalt |-> resetOut)
        else reportError("resetOut not raised after halt decode");
    haltHolds: assert property (@(posedge clock) resetOut && !reset |=> resetOut)
        else reportError("resetOut dropped before reset");
    haltQuiet: assert property (@(posedge clock) resetOut |-> strobes == '0)
        else reportError("strobe active while halted");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected kind, length and ALU operation of one instruction
    task automatic applyInstr(input logic [5:0] op, input logic [5:0] fn);
        int execLength;
        opcode      = opcodeT'(op);
        funct       = functT'(fn);
        expKind     = (op == 6'h3f) ? kindHalt : kindNone;
        expAlu      = aluPass;
        execLength  = 0;
        for (int k = 0; k < 6; k++) begin
            if (op == knownOp[k] && (op == 6'h08 || fn == knownFn[k])) begin
                expKind    = knownKind[k];
                expAlu     = knownAlu[k];
                execLength = knownLength[k];
            end
        end
        expMemToReg = (expKind == kindSlt) ? 4'd4 : 4'd0;
        expGap      = memWaitCycles + 3 + execLength;
        expWrites   = (expKind == kindNone || expKind == kindHalt) ? 0 : 1;
    endtask

    task automatic buildProgram();
        int choice;
        logic [5:0] op;
        logic [5:0] fn;
        for (int i = 0; i < 6; i++) begin
            progOp[i] = knownOp[i];
            progFn[i] = knownFn[i];
        end
        progOp[6] = 6'h00;
        progFn[6] = 6'h03;                                    // sra
        progOp[7] = 6'h23;
        progFn[7] = 6'h20;                                    // Load word, not supported
        for (int i = 0; i < fillerCount; i++) begin
            rngState = xorshift(rngState);
            choice   = int'(rngState[2:0]);
            op       = rngState[13:8];
            fn       = rngState[21:16];
            if (choice < 6) begin
                op = knownOp[choice];
                fn = knownFn[choice];
            end else if (choice == 6) begin
                if (op == 6'h00 || op == 6'h08 || op == 6'h3f) begin
                    op = 6'h23;                               // Load word, not supported
                end
            end else begin
                op = 6'h00;
                if (fn == 6'h20 || fn == 6'h22 || fn == 6'h24 || fn == 6'h2a || fn == 6'h00) begin
                    fn = 6'h03;
                end
            end
            progOp[fixedCount + i] = op;
            progFn[fixedCount + i] = fn;
        end
        progOp[programLength - 1] = 6'h3f;
        progFn[programLength - 1] = 6'h00;
    endtask

    task automatic waitFetch();
        do begin
            @(negedge clock);
        end while (irWrite !== 1'b1);
    endtask

    initial begin
        resetRequest = 1'b0;
        rngState     = 32'ha4ebdb86;
        buildProgram();
        applyInstr(6'h00, 6'h20);
        for (int i = 0; i < programLength; i++) begin
            waitFetch();
            @(posedge clock);
            #driveDelay;
            applyInstr(progOp[i], progFn[i]);                 // Decoded two cycles later
        end
        repeat (haltHold) @(posedge clock);
        #driveDelay;
        resetRequest = 1'b1;
        repeat (2) @(posedge clock);
        #driveDelay;
        resetRequest = 1'b0;
        waitFetch();
        @(posedge clock);
        #driveDelay;
        applyInstr(6'h00, 6'h22);
        waitFetch();
        repeat (2) @(posedge clock);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clock);
        $display("The run timed out after %0d cycles without finishing the program",
                 timeoutCycles);
        abortRun();
    end

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/10ps

module clockGen #(
    parameter int halfPeriod  = 50,
    parameter int resetCycles = 2,
    parameter int driveDelay  = 10
) (
    input  logic resetRequest,
    output logic clock,
    output logic reset
);

    logic startupReset;

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    initial begin
        startupReset = 1'b1;
        repeat (resetCycles) @(posedge clock);
        #driveDelay;
        startupReset = 1'b0;
    end

    assign reset = startupReset | resetRequest;           // Later resets come from the testbench

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit import controlPkg::*; #(
    parameter int memWaitCycles = 3
) (
    input  logic                         clock,
    input  logic                         reset,

    input  opcodeT                       opcode,
    input  functT                        funct,

    output logic                         pcWrite,
    output logic                         memReadWrite,
    output logic                         irWrite,
    output logic                         regWrite,
    output logic                         aWrite,
    output logic                         bWrite,
    output logic                         aluOutWrite,

    output aluOpT                        aluOp,

    output logic                         srcASel,
    output logic [srcBSelWidth-1:0]      srcBSel,
    output logic [regDestSelWidth-1:0]   regDestSel,
    output logic [memToRegSelWidth-1:0]  memToRegSel,
    output logic                         shiftAmtSel,
    output logic                         shiftSrcSel,
    output shiftOpT                      shiftCtrl,

    output logic                         resetOut
);

    instrT                instr;
    phaseT                phase;
    logic [stepWidth-1:0] step;

    instrDecode decoder (
        .opcode (opcode),
        .funct  (funct),
        .instr  (instr)
    );

    controlSequencer #(
        .memWaitCycles (memWaitCycles)
    ) sequencer (
        .clock (clock),
        .reset (reset),
        .instr (instr),
        .phase (phase),
        .step  (step)
    );

    controlOutputs outputTable (
        .phase        (phase),
        .step         (step),
        .pcWrite      (pcWrite),
        .memReadWrite (memReadWrite),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .aWrite       (aWrite),
        .bWrite       (bWrite),
        .aluOutWrite  (aluOutWrite),
        .aluOp        (aluOp),
        .srcASel      (srcASel),
        .srcBSel      (srcBSel),
        .regDestSel   (regDestSel),
        .memToRegSel  (memToRegSel),
        .shiftAmtSel  (shiftAmtSel),
        .shiftSrcSel  (shiftSrcSel),
        .shiftCtrl    (shiftCtrl),
        .resetOut     (resetOut)
    );

endmodule

// ==== src/controlOutputs.sv ====
`timescale 1ns/10ps

module controlOutputs import controlPkg::*; (
    input  phaseT                        phase,
    input  logic [stepWidth-1:0]         step,

    output logic                         pcWrite,
    output logic                         memReadWrite,
    output logic                         irWrite,
    output logic                         regWrite,
    output logic                         aWrite,
    output logic                         bWrite,
    output logic                         aluOutWrite,

    output aluOpT                        aluOp,

    output logic                         srcASel,
    output logic [srcBSelWidth-1:0]      srcBSel,
    output logic [regDestSelWidth-1:0]   regDestSel,
    output logic [memToRegSelWidth-1:0]  memToRegSel,
    output logic                         shiftAmtSel,
    output logic                         shiftSrcSel,
    output shiftOpT                      shiftCtrl,

    output logic                         resetOut
);

    always_comb begin
        pcWrite      = 1'b0;
        memReadWrite = 1'b0;                          // Memory is only ever read
        irWrite      = 1'b0;
        regWrite     = 1'b0;
        aWrite       = 1'b0;
        bWrite       = 1'b0;
        aluOutWrite  = 1'b0;
        aluOp        = aluPass;
        srcASel      = 1'b0;
        srcBSel      = '0;
        regDestSel   = '0;
        memToRegSel  = '0;
        shiftAmtSel  = 1'b0;
        shiftSrcSel  = 1'b0;
        shiftCtrl    = shiftNone;
        resetOut     = 1'b0;

        case (phase)
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Shared fetch and decode
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

            phaseFetchWait: begin
                aluOp   = aluAdd;                     // PC plus four ready early
                srcBSel = srcBSelWidth'(1);
            end

            phaseFetchLatch: begin
                aluOp   = aluAdd;
                srcBSel = srcBSelWidth'(1);
                pcWrite = 1'b1;
                irWrite = 1'b1;
            end

            phaseRegRead: begin
                aWrite  = 1'b1;
                bWrite  = 1'b1;
                srcBSel = srcBSelWidth'(1);
            end

            phaseDecode: begin
                aluOp = aluPass;                      // Idle while the opcode settles
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Execute sequences
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

            phaseAdd, phaseSub, phaseAnd: begin
                case (phase)
                    phaseSub: aluOp = aluSub;
                    phaseAnd: aluOp = aluAnd;
                    default:  aluOp = aluAdd;
                endcase
                srcASel     = 1'b1;
                aluOutWrite = 1'b1;
                if (step == stepWidth'(1)) begin
                    regWrite   = 1'b1;                // Result goes to rd
                    regDestSel = regDestSelWidth'(1);
                end
            end

            phaseAddi: begin
                aluOp   = aluAdd;
                srcASel = 1'b1;
                srcBSel = srcBSelWidth'(2);           // Sign-extended immediate
                if (step == '0) begin
                    aluOutWrite = 1'b1;
                end else begin
                    regWrite = 1'b1;                  // Result goes to rt
                end
            end

            phaseSll: begin
                regDestSel  = regDestSelWidth'(1);
                memToRegSel = memToRegSelWidth'(8);   // Write back from the shifter
                if (step == '0) begin
                    shiftCtrl   = shiftLoad;
                    shiftAmtSel = 1'b1;
                    shiftSrcSel = 1'b1;
                end else begin
                    shiftCtrl = shiftLeft;
                end
                if (step == stepWidth'(2)) begin
                    regWrite = 1'b1;
                end
            end

            phaseSlt: begin
                aluOp       = aluSlt;
                srcASel     = 1'b1;
                regDestSel  = regDestSelWidth'(1);
                memToRegSel = memToRegSelWidth'(4);   // Write back the compare flag
                regWrite    = 1'b1;
            end

            phaseHalt: begin
                resetOut = 1'b1;
            end

            default: begin
                resetOut = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer import controlPkg::*; #(
    parameter int memWaitCycles = 3
) (
    input  logic                 clock,
    input  logic                 reset,
    input  instrT                instr,
    output phaseT                phase,
    output logic [stepWidth-1:0] step
);

    localparam int waitWidth = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;
    localparam logic [waitWidth-1:0] lastWait = waitWidth'(memWaitCycles - 1);

    logic [waitWidth-1:0] waitCount;
    logic [waitWidth-1:0] waitNext;
    phaseT                phaseNext;
    logic [stepWidth-1:0] stepNext;
    logic [stepWidth-1:0] lastStep;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute phase lengths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (phase)
            phaseAdd, phaseSub, phaseAnd, phaseAddi: begin
                lastStep = stepWidth'(1);             // Compute, then write back
            end
            phaseSll: begin
                lastStep = stepWidth'(2);             // Load, shift, shift and write
            end
            default: begin
                lastStep = '0;                        // Slt finishes in one cycle
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next phase
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        phaseNext = phase;
        stepNext  = '0;
        waitNext  = '0;

        case (phase)
            phaseFetchWait: begin
                if (waitCount == lastWait) begin
                    phaseNext = phaseFetchLatch;
                end else begin
                    waitNext = waitCount + waitWidth'(1);
                end
            end

            phaseFetchLatch: begin
                phaseNext = phaseRegRead;
            end

            phaseRegRead: begin
                phaseNext = phaseDecode;
            end

            phaseDecode: begin
                case (instr)                          // Opcode and funct are valid here
                    instrAdd:  phaseNext = phaseAdd;
                    instrSub:  phaseNext = phaseSub;
                    instrAnd:  phaseNext = phaseAnd;
                    instrAddi: phaseNext = phaseAddi;
                    instrSll:  phaseNext = phaseSll;
                    instrSlt:  phaseNext = phaseSlt;
                    instrHalt: phaseNext = phaseHalt;
                    default:   phaseNext = phaseFetchWait;
                endcase
            end

            phaseAdd, phaseSub, phaseAnd, phaseAddi, phaseSll, phaseSlt: begin
                if (step == lastStep) begin
                    phaseNext = phaseFetchWait;
                end else begin
                    stepNext = step + stepWidth'(1);
                end
            end

            phaseHalt: begin
                phaseNext = phaseHalt;                // Left only through reset
            end

            default: begin
                phaseNext = phaseFetchWait;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase     <= phaseFetchWait;
            step      <= '0;
            waitCount <= '0;
        end else begin
            phase     <= phaseNext;
            step      <= stepNext;
            waitCount <= waitNext;
        end
    end

endmodule

// ==== src/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode import controlPkg::*; (
    input  opcodeT opcode,
    input  functT  funct,
    output instrT  instr
);

    // Only instructions with an execute sequence get a kind of their own
    always_comb begin
        case (opcode)
            opR: begin
                case (funct)
                    fnAdd: begin
                        instr = instrAdd;
                    end
                    fnSub: begin
                        instr = instrSub;
                    end
                    fnAnd: begin
                        instr = instrAnd;
                    end
                    fnSll: begin
                        instr = instrSll;
                    end
                    fnSlt: begin
                        instr = instrSlt;
                    end
                    default: begin
                        instr = instrNone;                // Includes sra
                    end
                endcase
            end

            opAddi: begin
                instr = instrAddi;
            end

            opHalt: begin
                instr = instrHalt;
            end

            default: begin
                instr = instrNone;
            end
        endcase
    end

endmodule

// ==== src/controlPkg.sv ====
package controlPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [5:0] {
        opR    = 6'b000000,                   // R-type, operation chosen by funct
        opAddi = 6'b001000,
        opHalt = 6'b111111                    // Stops the machine until reset
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll = 6'b000000,
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnSlt = 6'b101010
    } functT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded kind and sequencer phase
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        instrAdd,
        instrSub,
        instrAnd,
        instrAddi,
        instrSll,
        instrSlt,
        instrHalt,
        instrNone                             // Anything without an execute sequence
    } instrT;

    typedef enum logic [3:0] {
        phaseFetchWait,                       // Waiting on instruction memory
        phaseFetchLatch,
        phaseRegRead,
        phaseDecode,
        phaseAdd,
        phaseSub,
        phaseAnd,
        phaseAddi,
        phaseSll,
        phaseSlt,
        phaseHalt
    } phaseT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath commands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        aluPass = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3,
        aluSlt  = 3'd7
    } aluOpT;

    typedef enum logic [2:0] {
        shiftNone = 3'd0,
        shiftLoad = 3'd1,                     // Load the shifter from its source
        shiftLeft = 3'd2
    } shiftOpT;

    localparam int stepWidth        = 2;     // Longest execute phase is three steps
    localparam int srcBSelWidth     = 2;
    localparam int regDestSelWidth  = 2;
    localparam int memToRegSelWidth = 4;

endpackage
